// File: verilog/spm_pkg.sv
package spm_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////
    localparam int data_w = 32;              // Coordinates, offsets and DAC words
    localparam int q_rot  = 28;              // Fraction bits of cos/sin pair
    localparam int prod_w = 2*data_w;        // Full rotation product
    localparam int rot_w  = prod_w - q_rot;  // Rotated coordinate after the shift
    localparam int sum_w  = rot_w + 1;       // Offset sum ahead of the clamp

    // Sample buffer between generator and controller
    localparam int fifo_depth = 16;
    localparam int fifo_aw    = 4;

    // Symmetric DAC clamp, negative limit is -sat_max
    localparam logic signed [data_w-1:0] sat_max = 32'sh7fff_ffff;

    // Register byte addresses
    typedef enum logic [5:0] {
        reg_ctrl   = 6'h00,  // Bit 0 start on write, busy on read
        reg_pitch  = 6'h04,  // Raster pitch
        reg_points = 6'h08,  // Points per line, 16 bit
        reg_lines  = 6'h0C,  // Lines per frame, 16 bit
        reg_rot_xx = 6'h10,  // cos(alpha)
        reg_rot_xy = 6'h14,  // sin(alpha)
        reg_x0     = 6'h18,
        reg_y0     = 6'h1C,
        reg_z0     = 6'h20,
        reg_step   = 6'h24   // Offset slew limit, unsigned
    } reg_addr_e;

    // Raster generator states
    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_flush   // Last sample waiting for accept
    } scan_state_e;

endpackage

// File: verilog/spm_axil_regs.sv
`timescale 1ns/10ps

module spm_axil_regs
    import spm_pkg::*;
(
    input  logic              a_clk,
    input  logic              reset,
    // Write address / data / response
    input  logic [5:0]        s_axil_awaddr,
    input  logic              s_axil_awvalid,
    output logic              s_axil_awready,
    input  logic [31:0]       s_axil_wdata,
    input  logic              s_axil_wvalid,
    output logic              s_axil_wready,
    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  logic              s_axil_bready,
    // Read address / data
    input  logic [5:0]        s_axil_araddr,
    input  logic              s_axil_arvalid,
    output logic              s_axil_arready,
    output logic [31:0]       s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  logic              s_axil_rready,
    input  logic              busy,
    output logic              start,
    output logic [data_w-1:0] pitch,
    output logic [15:0]       points,
    output logic [15:0]       lines,
    output logic [data_w-1:0] rot_xx,
    output logic [data_w-1:0] rot_xy,
    output logic [data_w-1:0] x0,
    output logic [data_w-1:0] y0,
    output logic [data_w-1:0] z0,
    output logic [data_w-1:0] step
);

    reg_addr_e wr_addr;
    reg_addr_e rd_addr;
    logic      wr_en;   // Write handshake cycle
    logic      rd_en;   // Read handshake cycle

    assign wr_addr = reg_addr_e'(s_axil_awaddr);
    assign rd_addr = reg_addr_e'(s_axil_araddr);
    assign wr_en   = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
    assign rd_en   = s_axil_arready && s_axil_arvalid;

    assign s_axil_wready = s_axil_awready;  // AW and W taken together
    assign s_axil_bresp  = 2'b00;           // Always OKAY
    assign s_axil_rresp  = 2'b00;

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            s_axil_awready <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            start          <= 1'b0;
            pitch          <= '0;
            points         <= '0;
            lines          <= '0;
            rot_xx         <= data_w'(1) << q_rot;  // Identity rotation
            rot_xy         <= '0;
            x0             <= '0;
            y0             <= '0;
            z0             <= '0;
            step           <= '0;
        end
        else
        begin
            start <= 1'b0;
            // One-cycle ready pulses, no new request while a response is pending
            s_axil_awready <= !s_axil_awready && !s_axil_bvalid &&
                              s_axil_awvalid && s_axil_wvalid;
            s_axil_arready <= !s_axil_arready && !s_axil_rvalid && s_axil_arvalid;

            if (wr_en)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;

            if (rd_en)
                s_axil_rvalid <= 1'b1;
            else if (s_axil_rready)
                s_axil_rvalid <= 1'b0;

            if (wr_en)
            begin
                case (wr_addr)
                    reg_ctrl:   start  <= s_axil_wdata[0] && !busy;  // Ignored mid-scan
                    reg_pitch:  pitch  <= s_axil_wdata;
                    reg_points: points <= s_axil_wdata[15:0];
                    reg_lines:  lines  <= s_axil_wdata[15:0];
                    reg_rot_xx: rot_xx <= s_axil_wdata;
                    reg_rot_xy: rot_xy <= s_axil_wdata;
                    reg_x0:     x0     <= s_axil_wdata;
                    reg_y0:     y0     <= s_axil_wdata;
                    reg_z0:     z0     <= s_axil_wdata;
                    reg_step:   step   <= s_axil_wdata;
                    default:    ;                            // Unmapped, dropped
                endcase
            end
        end
    end

    // Read data, captured on the address handshake
    always_ff @(posedge a_clk)
    begin
        if (rd_en)
        begin
            case (rd_addr)
                reg_ctrl:   s_axil_rdata <= {31'b0, busy};
                reg_pitch:  s_axil_rdata <= pitch;
                reg_points: s_axil_rdata <= {16'b0, points};
                reg_lines:  s_axil_rdata <= {16'b0, lines};
                reg_rot_xx: s_axil_rdata <= rot_xx;
                reg_rot_xy: s_axil_rdata <= rot_xy;
                reg_x0:     s_axil_rdata <= x0;
                reg_y0:     s_axil_rdata <= y0;
                reg_z0:     s_axil_rdata <= z0;
                reg_step:   s_axil_rdata <= step;
                default:    s_axil_rdata <= '0;
            endcase
        end
    end

    // Responses hold until the master takes them
    a_b_hold: assert property (@(posedge a_clk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);
    a_r_hold: assert property (@(posedge a_clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// File: verilog/scan_raster_gen.sv
`timescale 1ns/10ps

module scan_raster_gen
    import spm_pkg::*;
(
    input  logic              a_clk,
    input  logic              reset,
    input  logic              start,
    input  logic [data_w-1:0] pitch,
    input  logic [15:0]       points,
    input  logic [15:0]       lines,
    input  logic              gen_ready,
    output logic              busy,
    output logic              gen_valid,
    output logic [data_w-1:0] gen_xs,
    output logic [data_w-1:0] gen_ys
);

    scan_state_e state;
    logic [15:0] i_cnt;     // Point index within the line
    logic [31:0] left;      // Samples still to come after the current one
    logic [31:0] total;     // points x lines
    logic        fire;
    logic        line_end;

    assign total    = 32'(points) * 32'(lines);
    assign fire     = gen_valid && gen_ready;
    assign line_end = (i_cnt == points - 16'd1);
    assign busy     = (state != st_idle);

    //////////////////////////////////////////////////
    // Scan FSM
    //////////////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            state     <= st_idle;
            gen_valid <= 1'b0;
            i_cnt     <= '0;
            left      <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (start && total != '0)  // Empty raster never starts
                    begin
                        state     <= (total == 32'd1) ? st_flush : st_run;
                        gen_valid <= 1'b1;
                        i_cnt     <= '0;
                        left      <= total - 32'd1;
                    end
                st_run:
                    if (fire)
                    begin
                        i_cnt <= line_end ? 16'd0 : i_cnt + 16'd1;
                        left  <= left - 32'd1;
                        if (left == 32'd1)
                            state <= st_flush;  // Next offer is the final one
                    end
                st_flush:
                    if (fire)
                    begin
                        state     <= st_idle;
                        gen_valid <= 1'b0;
                    end
                default: state <= st_idle;
            endcase
        end
    end

    // Coordinates by accumulation, xs = i*pitch, ys = j*pitch mod 2^32
    always_ff @(posedge a_clk)
    begin
        if (state == st_idle && start)
        begin
            gen_xs <= '0;
            gen_ys <= '0;
        end
        else if (state == st_run && fire)
        begin
            if (line_end)
            begin
                gen_xs <= '0;               // Back to line start
                gen_ys <= gen_ys + pitch;   // Next line
            end
            else
                gen_xs <= gen_xs + pitch;
        end
    end

    a_gen_hold: assert property (@(posedge a_clk) disable iff (reset)
        gen_valid && !gen_ready |=> gen_valid && $stable(gen_xs) && $stable(gen_ys));

endmodule

// File: verilog/scan_fifo.sv
`timescale 1ns/10ps

module scan_fifo
    import spm_pkg::*;
(
    input  logic              a_clk,
    input  logic              reset,
    input  logic              in_valid,
    input  logic [data_w-1:0] in_xs,
    input  logic [data_w-1:0] in_ys,
    input  logic              out_ready,
    output logic              in_ready,
    output logic              out_valid,
    output logic [data_w-1:0] out_xs,
    output logic [data_w-1:0] out_ys
);

    logic [data_w-1:0]  mem_xs [fifo_depth];
    logic [data_w-1:0]  mem_ys [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;     // Entries in the array, output reg excluded
    logic               in_fire;
    logic               load_out;  // Output register free this cycle
    logic               pop;
    logic               push;
    logic               bypass;    // Empty array, input straight to output

    assign in_ready = (count != (fifo_aw+1)'(fifo_depth));
    assign in_fire  = in_valid && in_ready;
    assign load_out = !out_valid || out_ready;
    assign pop      = load_out && (count != '0);
    assign bypass   = load_out && (count == '0) && in_fire;
    assign push     = in_fire && !bypass;

    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (fifo_aw+1)'(push) - (fifo_aw+1)'(pop);
            if (load_out)
                out_valid <= pop || bypass;
        end
    end

    // Storage and output register
    always_ff @(posedge a_clk)
    begin
        if (push)
        begin
            mem_xs[wr_ptr] <= in_xs;
            mem_ys[wr_ptr] <= in_ys;
        end
        if (pop)
        begin
            out_xs <= mem_xs[rd_ptr];  // Oldest entry first
            out_ys <= mem_ys[rd_ptr];
        end
        else if (bypass)
        begin
            out_xs <= in_xs;
            out_ys <= in_ys;
        end
    end

    a_fifo_count: assert property (@(posedge a_clk) disable iff (reset)
        count <= (fifo_aw+1)'(fifo_depth));

endmodule

// File: verilog/spm_position_ctrl.sv
`timescale 1ns/10ps

module spm_position_ctrl
    import spm_pkg::*;
(
    input  logic                     a_clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic signed [data_w-1:0] in_xs,
    input  logic signed [data_w-1:0] in_ys,
    input  logic signed [data_w-1:0] z_servo,   // Z feedback word
    input  logic signed [data_w-1:0] rot_xx,    // cos, Q28
    input  logic signed [data_w-1:0] rot_xy,    // sin, Q28
    input  logic signed [data_w-1:0] x0,
    input  logic signed [data_w-1:0] y0,
    input  logic signed [data_w-1:0] z0,
    input  logic        [data_w-1:0] step,
    input  logic                     out_ready,
    output logic                     in_ready,
    output logic                     out_valid,
    output logic signed [data_w-1:0] x_out,
    output logic signed [data_w-1:0] y_out,
    output logic signed [data_w-1:0] z_out
);

    // Move cur toward tgt by at most stp
    function automatic logic signed [data_w-1:0] slew(
        input logic signed [data_w-1:0] cur,
        input logic signed [data_w-1:0] tgt,
        input logic        [data_w-1:0] stp
    );
        logic signed [data_w:0] diff;  // Guard bit keeps the distance exact
        logic signed [data_w:0] lim;
        diff = (data_w+1)'(tgt) - (data_w+1)'(cur);
        lim  = $signed({1'b0, stp});
        if (diff > lim)
            slew = cur + stp;
        else if (diff < -lim)
            slew = cur - stp;
        else
            slew = tgt;                 // Within one step, land on it
    endfunction

    // Clamp to +/- sat_max
    function automatic logic signed [data_w-1:0] sat(input logic signed [sum_w-1:0] v);
        if (v > sum_w'(sat_max))
            sat = sat_max;
        else if (v < -sum_w'(sat_max))
            sat = -sat_max;
        else
            sat = v[data_w-1:0];
    endfunction

    logic                     adv;      // Pipeline moves this cycle
    logic                     in_fire;
    logic signed [prod_w-1:0] rot_x;    // Rotated and shifted, full width
    logic signed [prod_w-1:0] rot_y;
    logic                     v1;       // Stage 1 full
    logic signed [rot_w-1:0]  xr1;
    logic signed [rot_w-1:0]  yr1;
    logic signed [data_w-1:0] zs1;      // Servo word taken with the sample
    logic signed [data_w-1:0] ox;       // Slewed offsets
    logic signed [data_w-1:0] oy;
    logic signed [data_w-1:0] oz;
    logic signed [sum_w-1:0]  sum_x;
    logic signed [sum_w-1:0]  sum_y;
    logic signed [sum_w-1:0]  sum_z;

    assign adv      = !out_valid || out_ready;
    assign in_ready = adv;
    assign in_fire  = in_valid && adv;

    // Xr =  xx*xs + xy*ys,  Yr = -xy*xs + xx*ys
    assign rot_x = (prod_w'(rot_xx) * prod_w'(in_xs) + prod_w'(rot_xy) * prod_w'(in_ys))
                   >>> q_rot;
    assign rot_y = (prod_w'(rot_xx) * prod_w'(in_ys) - prod_w'(rot_xy) * prod_w'(in_xs))
                   >>> q_rot;

    assign sum_x = sum_w'(xr1) + sum_w'(ox);
    assign sum_y = sum_w'(yr1) + sum_w'(oy);
    assign sum_z = sum_w'(zs1) + sum_w'(oz);

    //////////////////////////////////////////////////
    // Valids and offset accumulators
    //////////////////////////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            v1        <= 1'b0;
            out_valid <= 1'b0;
            ox        <= '0;
            oy        <= '0;
            oz        <= '0;
        end
        else if (adv)
        begin
            v1        <= in_valid;
            out_valid <= v1;
            if (in_valid)
            begin
                // One slew step per accepted sample
                ox <= slew(ox, x0, step);
                oy <= slew(oy, y0, step);
                oz <= slew(oz, z0, step);
            end
        end
    end

    // Stage 1 rotation, stage 2 offset sum and clamp
    always_ff @(posedge a_clk)
    begin
        if (in_fire)
        begin
            xr1 <= rot_x[rot_w-1:0];  // Upper bits only sign
            yr1 <= rot_y[rot_w-1:0];
            zs1 <= z_servo;
        end
        if (adv && v1)
        begin
            x_out <= sat(sum_x);
            y_out <= sat(sum_y);
            z_out <= sat(sum_z);
        end
    end

    a_out_hold: assert property (@(posedge a_clk) disable iff (reset)
        out_valid && !out_ready |=>
            out_valid && $stable(x_out) && $stable(y_out) && $stable(z_out));

endmodule

// File: verilog/spm_top.sv
`timescale 1ns/10ps

module spm_top
    import spm_pkg::*;
(
    input  logic              a_clk,
    input  logic              reset,
    input  logic [5:0]        s_axil_awaddr,
    input  logic              s_axil_awvalid,
    output logic              s_axil_awready,
    input  logic [31:0]       s_axil_wdata,
    input  logic              s_axil_wvalid,
    output logic              s_axil_wready,
    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  logic              s_axil_bready,
    input  logic [5:0]        s_axil_araddr,
    input  logic              s_axil_arvalid,
    output logic              s_axil_arready,
    output logic [31:0]       s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  logic              s_axil_rready,
    input  logic [data_w-1:0] z_servo,
    input  logic              out_ready,
    output logic              out_valid,
    output logic [data_w-1:0] x_out,
    output logic [data_w-1:0] y_out,
    output logic [data_w-1:0] z_out
);

    // Configuration levels from the register block
    logic              start;
    logic              busy;
    logic [data_w-1:0] pitch;
    logic [15:0]       points;
    logic [15:0]       lines;
    logic [data_w-1:0] rot_xx;
    logic [data_w-1:0] rot_xy;
    logic [data_w-1:0] x0;
    logic [data_w-1:0] y0;
    logic [data_w-1:0] z0;
    logic [data_w-1:0] step;

    // Sample streams
    logic              gen_valid;
    logic              gen_ready;
    logic [data_w-1:0] gen_xs;
    logic [data_w-1:0] gen_ys;
    logic              fifo_valid;
    logic              fifo_ready;
    logic [data_w-1:0] fifo_xs;
    logic [data_w-1:0] fifo_ys;

    spm_axil_regs i_regs (
        .a_clk          (a_clk),
        .reset          (reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .busy           (busy),
        .start          (start),
        .pitch          (pitch),
        .points         (points),
        .lines          (lines),
        .rot_xx         (rot_xx),
        .rot_xy         (rot_xy),
        .x0             (x0),
        .y0             (y0),
        .z0             (z0),
        .step           (step)
    );

    scan_raster_gen i_gen (
        .a_clk     (a_clk),
        .reset     (reset),
        .start     (start),
        .pitch     (pitch),
        .points    (points),
        .lines     (lines),
        .gen_ready (gen_ready),
        .busy      (busy),
        .gen_valid (gen_valid),
        .gen_xs    (gen_xs),
        .gen_ys    (gen_ys)
    );

    scan_fifo i_fifo (
        .a_clk     (a_clk),
        .reset     (reset),
        .in_valid  (gen_valid),
        .in_xs     (gen_xs),
        .in_ys     (gen_ys),
        .out_ready (fifo_ready),
        .in_ready  (gen_ready),
        .out_valid (fifo_valid),
        .out_xs    (fifo_xs),
        .out_ys    (fifo_ys)
    );

    spm_position_ctrl i_ctrl (
        .a_clk     (a_clk),
        .reset     (reset),
        .in_valid  (fifo_valid),
        .in_xs     (fifo_xs),
        .in_ys     (fifo_ys),
        .z_servo   (z_servo),
        .rot_xx    (rot_xx),
        .rot_xy    (rot_xy),
        .x0        (x0),
        .y0        (y0),
        .z0        (z0),
        .step      (step),
        .out_ready (out_ready),
        .in_ready  (fifo_ready),
        .out_valid (out_valid),
        .x_out     (x_out),
        .y_out     (y_out),
        .z_out     (z_out)
    );

endmodule

// File: tests/tb_spm_top.sv
`timescale 1ns/10ps

module tb_spm_top
    import spm_pkg::*;
;

    localparam int n_samples  = 450;                  // Sum of points x lines over all scans
    localparam int max_cycles = 10*n_samples + 2000;

    logic        a_clk;
    logic        reset;
    logic [5:0]  s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [5:0]  s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;
    logic [31:0] z_servo;
    logic        out_ready = 1'b0;
    logic        out_valid;
    logic [31:0] x_out;
    logic [31:0] y_out;
    logic [31:0] z_out;

    // Expected samples from the model in output order
    logic [31:0] mx [1024];
    logic [31:0] my [1024];
    logic [31:0] mz [1024];
    logic [9:0]  wr_n = '0;
    logic [9:0]  rd_n = '0;
    logic [31:0] exp_x;
    logic [31:0] exp_y;
    logic [31:0] exp_z;
    logic        have_exp;

    logic [31:0] off_x = '0;        // Model offsets start from zero
    logic [31:0] off_y = '0;
    logic [31:0] off_z = '0;
    logic [31:0] rnd = 32'hd3092ded;
    logic        random_ready = 1'b0;
    int          cycles = 0;
    int          err_x = 0;
    int          err_y = 0;
    int          err_z = 0;
    int          err_reg = 0;
    int          err_other = 0;

    spm_top i_dut (.*);

    assign exp_x    = mx[rd_n];
    assign exp_y    = my[rd_n];
    assign exp_z    = mz[rd_n];
    assign have_exp = (rd_n != wr_n);

    //////////////////////////////////////////////////
    // Reference model helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Offset moves by at most stp toward its target
    function automatic logic [31:0] slew_toward(input logic [31:0] cur, input logic [31:0] tgt,
                                                input logic [31:0] stp);
        longint d;
        longint s;
        d = longint'($signed(tgt)) - longint'($signed(cur));
        s = {32'd0, stp};
        if (d > s)
            return cur + stp;
        else if (d < -s)
            return cur - stp;
        return tgt;
    endfunction

    function automatic logic [31:0] clamp(input longint v);
        if (v > 64'sd2147483647)
            return 32'h7fff_ffff;
        else if (v < -64'sd2147483647)
            return 32'h8000_0001;               // -(2^31-1)
        return v[31:0];
    endfunction

    //////////////////////////////////////////////////
    // Clock, out_ready, head tracking and watchdog
    //////////////////////////////////////////////////
    initial
    begin
        a_clk = 1'b0;
        forever #2 a_clk = ~a_clk;
    end

    always @(negedge a_clk)
    begin
        rnd = next_random(rnd);
        out_ready = random_ready ? rnd[0] : 1'b1;  // Random stalls in the long scan only
    end

    always @(posedge a_clk)
    begin
        if (!reset && out_valid && out_ready && have_exp)
            rd_n <= rd_n + 10'd1;   // Head consumed
    end

    always @(posedge a_clk)
    begin
        cycles = cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Run stopped by timeout after %0d cycles, %0d samples still missing",
                     cycles, int'(wr_n - rd_n));
            report_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Output checks against the head of the expected list
    a_x_out: assert property (@(posedge a_clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> x_out == exp_x)
        else
        begin
            err_x++;
            $display("ERROR at %0t: x_out expected %h, actual %h", $time,
                     $sampled(exp_x), $sampled(x_out));
        end
    a_y_out: assert property (@(posedge a_clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> y_out == exp_y)
        else
        begin
            err_y++;
            $display("ERROR at %0t: y_out expected %h, actual %h", $time,
                     $sampled(exp_y), $sampled(y_out));
        end
    a_z_out: assert property (@(posedge a_clk) disable iff (reset)
        out_valid && out_ready && have_exp |-> z_out == exp_z)
        else
        begin
            err_z++;
            $display("ERROR at %0t: z_out expected %h, actual %h", $time,
                     $sampled(exp_z), $sampled(z_out));
        end
    a_no_extra: assert property (@(posedge a_clk) disable iff (reset)
        out_valid && out_ready |-> have_exp)
        else
        begin
            err_other++;
            $display("Output sample accepted at %0t although none was expected", $time);
        end

    // AW and W ready rise together
    a_w_ready: assert property (@(posedge a_clk) disable iff (reset)
        s_axil_wready == s_axil_awready)
        else
        begin
            err_other++;
            $display("ERROR at %0t: s_axil_wready expected %b, actual %b", $time,
                     $sampled(s_axil_awready), $sampled(s_axil_wready));
        end

    task automatic report_counts();
        $display("Error counts: x_out=%0d y_out=%0d z_out=%0d register=%0d other=%0d",
                 err_x, err_y, err_z, err_reg, err_other);
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite master tasks start and end on a falling edge
    //////////////////////////////////////////////////
    task automatic axil_write(input logic [5:0] addr, input logic [31:0] data);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        do
            @(negedge a_clk);
        while (!s_axil_awready);    // Handshake on the next rising edge
        @(negedge a_clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid)
            @(negedge a_clk);
        assert (s_axil_bresp == 2'b00)
        else
        begin
            err_reg++;
            $display("ERROR at %0t: s_axil_bresp expected 0, actual %0d", $time, s_axil_bresp);
        end
        @(negedge a_clk);           // Response waits one cycle
        s_axil_bready = 1'b1;
        @(negedge a_clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        do
            @(negedge a_clk);
        while (!s_axil_arready);
        @(negedge a_clk);
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid)
            @(negedge a_clk);
        data = s_axil_rdata;
        assert (s_axil_rresp == 2'b00)
        else
        begin
            err_reg++;
            $display("ERROR at %0t: s_axil_rresp expected 0, actual %0d", $time, s_axil_rresp);
        end
        @(negedge a_clk);           // Read data waits one cycle
        s_axil_rready = 1'b1;
        @(negedge a_clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic check_reg(input logic [5:0] addr, input logic [31:0] want);
        logic [31:0] got;
        axil_read(addr, got);
        assert (got == want)
        else
        begin
            err_reg++;
            $display("ERROR at %0t: s_axil_rdata at 0x%h expected %h, actual %h",
                     $time, addr, want, got);
        end
    endtask

    // Configure and predict the scan before start and wait for the last output
    task automatic run_scan(input logic [31:0] pitch, input logic [15:0] pts,
                            input logic [15:0] lns, input logic [31:0] rxx, input logic [31:0] rxy,
                            input logic [31:0] ox, input logic [31:0] oy, input logic [31:0] oz,
                            input logic [31:0] stp, input logic [31:0] zs);
        int          i;
        int          j;
        logic [31:0] xs;
        logic [31:0] ys;
        longint      px;
        longint      py;
        axil_write(6'h04, pitch);
        axil_write(6'h08, {16'd0, pts});
        axil_write(6'h0C, {16'd0, lns});
        axil_write(6'h10, rxx);
        axil_write(6'h14, rxy);
        axil_write(6'h18, ox);
        axil_write(6'h1C, oy);
        axil_write(6'h20, oz);
        axil_write(6'h24, stp);
        z_servo = zs;           // Held for the whole scan
        for (j = 0; j < int'(lns); j++)
        begin
            for (i = 0; i < int'(pts); i++)
            begin
                xs = 32'(i) * pitch;
                ys = 32'(j) * pitch;
                off_x = slew_toward(off_x, ox, stp);   // One step per sample
                off_y = slew_toward(off_y, oy, stp);
                off_z = slew_toward(off_z, oz, stp);
                px = (longint'($signed(rxx)) * longint'($signed(xs))
                      + longint'($signed(rxy)) * longint'($signed(ys))) >>> q_rot;
                py = (longint'($signed(rxx)) * longint'($signed(ys))
                      - longint'($signed(rxy)) * longint'($signed(xs))) >>> q_rot;
                mx[wr_n] = clamp(px + longint'($signed(off_x)));
                my[wr_n] = clamp(py + longint'($signed(off_y)));
                mz[wr_n] = clamp(longint'($signed(zs)) + longint'($signed(off_z)));
                wr_n = wr_n + 10'd1;
            end
        end
        axil_write(6'h00, 32'h1);
        while (rd_n != wr_n)
            @(negedge a_clk);
        repeat (20) @(negedge a_clk);   // Window for any extra sample
        check_reg(6'h00, 32'h0);        // Busy low again
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial
    begin
        logic [5:0]  ra [9];
        logic [31:0] rv [9];
        logic [31:0] want;
        ra = '{6'h04, 6'h08, 6'h0C, 6'h10, 6'h14, 6'h18, 6'h1C, 6'h20, 6'h24};
        rv = '{32'hA5A5_0004, 32'hFFFF_1234, 32'h8001_00FF, 32'h1234_5678, 32'h9ABC_DEF0,
               32'h0F1E_2D3C, 32'hC3B2_A190, 32'h7654_3210, 32'h0000_00C8};
        reset          = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;      // Pulsed by the write task
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        z_servo        = '0;
        repeat (10) @(posedge a_clk);
        @(negedge a_clk);
        reset = 1'b0;

        // Register readback with 16-bit fields zero-extended
        for (int k = 0; k < 9; k++)
            axil_write(ra[k], rv[k]);
        axil_write(6'h2C, 32'hFFFF_FFFF);                   // Unmapped address
        for (int k = 0; k < 9; k++)
        begin
            want = (ra[k] == 6'h08 || ra[k] == 6'h0C) ? {16'd0, rv[k][15:0]} : rv[k];
            check_reg(ra[k], want);
        end
        check_reg(6'h2C, 32'h0);
        check_reg(6'h3C, 32'h0);
        check_reg(6'h00, 32'h0);

        // Raster order with identity rotation and no offsets
        run_scan(32'h0000_1000, 16'd5, 16'd4, 32'h1000_0000, 32'h0,
                 32'h0, 32'h0, 32'h0, 32'h0, 32'h0000_0123);
        // 90 degrees and then about 30 degrees with a negative pitch
        run_scan(32'h0000_0100, 16'd4, 16'd3, 32'h0, 32'h1000_0000,
                 32'h0, 32'h0, 32'h0, 32'h0, 32'h0000_0040);
        run_scan(32'hFFFF_F000, 16'd6, 16'd3, 32'h0DDB_3D74, 32'h0800_0000,
                 32'h0, 32'h0, 32'h0, 32'h0, 32'hFFFF_FFC0);
        // Offset slew takes 50 samples to reach x0
        run_scan(32'h0000_0010, 16'd8, 16'd8, 32'h1000_0000, 32'h0,
                 32'd5000, 32'hFFFF_F448, 32'd2500, 32'd100, 32'hFFFF_FF00);
        // Clamp in both directions
        run_scan(32'h1000_0000, 16'd12, 16'd3, 32'h1000_0000, 32'h0,
                 32'h9000_0000, 32'h7000_0000, 32'h7FFF_0000, 32'h4000_0000, 32'h7000_0000);
        // Long scan under random back-pressure
        random_ready = 1'b1;
        run_scan(32'h0000_0777, 16'd20, 16'd15, 32'h0DDB_3D74, 32'hF800_0000,
                 32'h0000_1000, 32'hFFFF_E000, 32'h0000_0800, 32'h0100_0000, 32'h0000_0055);
        random_ready = 1'b0;

        report_counts();
        if (err_x + err_y + err_z + err_reg + err_other == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: build.f
verilog/spm_pkg.sv
verilog/spm_axil_regs.sv
verilog/scan_raster_gen.sv
verilog/scan_fifo.sv
verilog/spm_position_ctrl.sv
verilog/spm_top.sv
tests/tb_spm_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_spm_top
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
